//--- hdl/carrierLoop_defines.svh
`ifndef CARRIER_LOOP_DEFINES_SVH
`define CARRIER_LOOP_DEFINES_SVH

// raw phase detector error width
`define RAW_ERR_W 12

// conditioned error width
`define ERR_W 8

// gain exponent width
`define EXP_W 5

// lead, lag, frequency word and phase accumulator width
`define ACC_W 32

// NCO phase bits brought out
`define PHASE_OUT_W 12

// consecutive small errors needed before lock
`define LOCK_COUNT 16

`endif

//--- hdl/carrierLoopPkg.sv
`include "carrierLoop_defines.svh"

package carrierLoopPkg;

    typedef logic signed [`RAW_ERR_W-1:0] rawError_t;
    typedef logic signed [`ERR_W-1:0]     loopError_t;
    typedef logic        [`EXP_W-1:0]     gainExp_t;   // 0 turns the path off
    typedef logic signed [`ACC_W-1:0]     loopAcc_t;
    typedef logic        [`PHASE_OUT_W-1:0] ncoPhase_t;

    typedef enum logic {
        SEARCH,
        LOCKED
    } lockState_t;

    // exponent ERR_W-1 leaves the error at its natural weight
    function automatic loopAcc_t scaleError(loopError_t err, gainExp_t gExp);
        loopAcc_t errExt;
        errExt = err; // sign extends
        if (gExp == '0) begin
            return '0;
        end else if (gExp < (`ERR_W - 1)) begin
            return errExt >>> ((`ERR_W - 1) - gExp);
        end else begin
            return errExt << (gExp - (`ERR_W - 1));
        end
    endfunction

endpackage

//--- hdl/errorConditioner.sv
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module errorConditioner (
    input  logic                    clk,
    input  logic                    reset,
    input  carrierLoopPkg::rawError_t  phaseError,
    input  logic                    errorValid,
    input  carrierLoopPkg::loopError_t lockThreshold,
    output carrierLoopPkg::loopError_t errSample,
    output logic                    errEn,
    output logic                    inSync
);

    localparam int DROP_W  = `RAW_ERR_W - `ERR_W;
    localparam int COUNT_W = $clog2(`LOCK_COUNT + 1);
    localparam logic signed [`RAW_ERR_W:0] HALF_LSB = 1 << (DROP_W - 1);
    localparam logic [COUNT_W-1:0] LOCK_CNT = COUNT_W'(`LOCK_COUNT);

    logic signed [`RAW_ERR_W:0] roundSum;   // one guard bit for the rounding carry
    logic signed [`ERR_W:0]     rounded;
    carrierLoopPkg::loopError_t errSat;
    logic        [`ERR_W-1:0]   errMag;
    logic signed [`ERR_W:0]     magExt;
    logic signed [`ERR_W:0]     thrExt;
    logic                       isSmall;

    carrierLoopPkg::lockState_t lockState;
    logic [COUNT_W-1:0]         smallCount;

    // round half up and drop the low bits
    assign roundSum = phaseError + HALF_LSB;
    assign rounded  = roundSum[`RAW_ERR_W:DROP_W];

    always_comb begin
        if (rounded[`ERR_W] != rounded[`ERR_W-1]) begin
            // out of range so pin to the rail on the sign side
            errSat = {rounded[`ERR_W], {(`ERR_W-1){~rounded[`ERR_W]}}};
        end else begin
            errSat = rounded[`ERR_W-1:0];
        end
    end

    assign errMag  = errSat[`ERR_W-1] ? -errSat : errSat; // -128 gives 128 unsigned
    assign magExt  = {1'b0, errMag};
    assign thrExt  = lockThreshold;
    assign isSmall = (magExt < thrExt);

    always_ff @(posedge clk) begin
        if (errorValid) begin
            errSample <= errSat;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            errEn <= 1'b0;
        end else begin
            errEn <= errorValid;  // single cycle since valids are spaced
        end
    end

    // lock FSM counting a run of small errors
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lockState  <= carrierLoopPkg::SEARCH;
            smallCount <= '0;
        end else if (errorValid) begin
            if (!isSmall) begin
                lockState  <= carrierLoopPkg::SEARCH;
                smallCount <= '0;
            end else if (lockState == carrierLoopPkg::SEARCH) begin
                if (smallCount == LOCK_CNT) begin
                    lockState <= carrierLoopPkg::LOCKED; // full run already counted so this one locks
                end else begin
                    smallCount <= smallCount + 1'b1;
                end
            end
        end
    end

    assign inSync = (lockState == carrierLoopPkg::LOCKED);

endmodule

//--- hdl/leadGain.sv
`timescale 1ns/1ps

module leadGain (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       errEn,
    input  carrierLoopPkg::loopError_t errSample,
    input  carrierLoopPkg::gainExp_t   leadExp,
    output carrierLoopPkg::loopAcc_t   leadTerm
);

    carrierLoopPkg::loopAcc_t leadNext;

    // proportional term, no memory beyond the current sample
    assign leadNext = carrierLoopPkg::scaleError(errSample, leadExp);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leadTerm <= '0;
        end else if (errEn) begin
            leadTerm <= leadNext;
        end
    end

endmodule

//--- hdl/lagGain.sv
`timescale 1ns/1ps

module lagGain (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       errEn,
    input  carrierLoopPkg::loopError_t errSample,
    input  carrierLoopPkg::gainExp_t   lagExp,
    input  carrierLoopPkg::loopAcc_t   limit,
    input  carrierLoopPkg::loopAcc_t   sweepOffsetMag,
    input  logic                       inSync,
    output carrierLoopPkg::loopAcc_t   lagAccum
);

    carrierLoopPkg::loopAcc_t lagError;     // scaled error of the previous sample
    carrierLoopPkg::loopAcc_t sweepOffset;  // added on this update
    carrierLoopPkg::loopAcc_t sweepMag;     // signed step, flips at each limit
    carrierLoopPkg::loopAcc_t upperLimit;
    carrierLoopPkg::loopAcc_t lowerLimit;
    carrierLoopPkg::loopAcc_t sum;

    assign upperLimit = limit;
    assign lowerLimit = -limit;
    assign sum        = lagAccum + lagError + sweepOffset;  // wraps

    // integrator state, lagError pipelines by one sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lagError    <= '0;
            lagAccum    <= '0;
            sweepOffset <= '0;
            sweepMag    <= '0;
        end else if (errEn) begin
            lagError <= carrierLoopPkg::scaleError(errSample, lagExp);
            if (inSync) begin
                lagAccum    <= sum;   // free running in lock
                sweepOffset <= '0;
            end else if (sum >= upperLimit) begin
                lagAccum    <= upperLimit;
                sweepOffset <= -sweepOffsetMag; // turn around, head down
                sweepMag    <= -sweepOffsetMag;
            end else if (sum <= lowerLimit) begin
                lagAccum    <= lowerLimit;
                sweepOffset <= sweepOffsetMag;  // head back up
                sweepMag    <= sweepOffsetMag;
            end else begin
                lagAccum    <= sum;
                sweepOffset <= sweepMag;
                if (sweepMag == '0) begin
                    // first pass after reset sweeps upward
                    sweepMag <= sweepOffsetMag;
                end
            end
        end
    end

endmodule

//--- hdl/loopNco.sv
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module loopNco (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      errEn,
    input  carrierLoopPkg::loopAcc_t  leadTerm,
    input  carrierLoopPkg::loopAcc_t  lagAccum,
    output carrierLoopPkg::loopAcc_t  freqWord,
    output carrierLoopPkg::ncoPhase_t ncoPhase
);

    logic                     errEnDly;  // lead and lag are settled one cycle after errEn
    carrierLoopPkg::loopAcc_t phaseAcc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            errEnDly <= 1'b0;
            freqWord <= '0;
        end else begin
            errEnDly <= errEn;
            if (errEnDly) begin
                freqWord <= leadTerm + lagAccum; // wrapping sum
            end
        end
    end

    // phase advances every clock, not just per sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phaseAcc <= '0;
        end else begin
            phaseAcc <= phaseAcc + freqWord;
        end
    end

    assign ncoPhase = phaseAcc[`ACC_W-1 -: `PHASE_OUT_W];

endmodule

//--- hdl/carrierLoop.sv
`timescale 1ns/1ps

module carrierLoop (
    input  logic                       clk,
    input  logic                       reset,
    input  carrierLoopPkg::rawError_t  phaseError,
    input  logic                       errorValid,
    input  carrierLoopPkg::gainExp_t   leadExp,
    input  carrierLoopPkg::gainExp_t   lagExp,
    input  carrierLoopPkg::loopAcc_t   limit,
    input  carrierLoopPkg::loopAcc_t   sweepOffsetMag,
    input  carrierLoopPkg::loopError_t lockThreshold,
    output carrierLoopPkg::loopAcc_t   freqWord,
    output carrierLoopPkg::ncoPhase_t  ncoPhase,
    output logic                       carrierInSync
);

    carrierLoopPkg::loopError_t errSample;
    logic                       errEn;
    logic                       inSync;
    carrierLoopPkg::loopAcc_t   leadTerm;
    carrierLoopPkg::loopAcc_t   lagAccum;

    errorConditioner conditioner (
        .clk           (clk),
        .reset         (reset),
        .phaseError    (phaseError),
        .errorValid    (errorValid),
        .lockThreshold (lockThreshold),
        .errSample     (errSample),
        .errEn         (errEn),
        .inSync        (inSync)
    );

    leadGain leadPath (
        .clk       (clk),
        .reset     (reset),
        .errEn     (errEn),
        .errSample (errSample),
        .leadExp   (leadExp),
        .leadTerm  (leadTerm)
    );

    lagGain lagPath (
        .clk            (clk),
        .reset          (reset),
        .errEn          (errEn),
        .errSample      (errSample),
        .lagExp         (lagExp),
        .limit          (limit),
        .sweepOffsetMag (sweepOffsetMag),
        .inSync         (inSync),
        .lagAccum       (lagAccum)
    );

    loopNco nco (
        .clk      (clk),
        .reset    (reset),
        .errEn    (errEn),
        .leadTerm (leadTerm),
        .lagAccum (lagAccum),
        .freqWord (freqWord),
        .ncoPhase (ncoPhase)
    );

    assign carrierInSync = inSync;

endmodule

//--- bench/carrierLoopTb.sv
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module carrierLoopTb;

    logic                       clk;
    logic                       reset;
    carrierLoopPkg::rawError_t  phaseError;
    logic                       errorValid;
    carrierLoopPkg::gainExp_t   leadExp;
    carrierLoopPkg::gainExp_t   lagExp;
    carrierLoopPkg::loopAcc_t   limit;
    carrierLoopPkg::loopAcc_t   sweepOffsetMag;
    carrierLoopPkg::loopError_t lockThreshold;
    carrierLoopPkg::loopAcc_t   freqWord;
    carrierLoopPkg::ncoPhase_t  ncoPhase;
    logic                       carrierInSync;

    // one entry per data line of the tests file
    int tagQ[$];
    int errQ[$];
    int leadQ[$];
    int lagQ[$];
    int limitQ[$];
    int sweepQ[$];
    int thrQ[$];
    int freqQ[$];
    int syncQ[$];

    int          cycleCount = 0;
    int          timeoutLimit = 0;
    logic [31:0] randState = 32'h8dca;
    int          thrCfg = 0;
    int          lockRun = 0;      // small samples seen in a row
    logic        lockModel = 1'b0;

    carrierLoopPkg::loopAcc_t phaseModel = '0;
    carrierLoopPkg::loopAcc_t lastFreq = '0;  // freqWord held before the coming edge

    carrierLoop UUT (
        .clk            (clk),
        .reset          (reset),
        .phaseError     (phaseError),
        .errorValid     (errorValid),
        .leadExp        (leadExp),
        .lagExp         (lagExp),
        .limit          (limit),
        .sweepOffsetMag (sweepOffsetMag),
        .lockThreshold  (lockThreshold),
        .freqWord       (freqWord),
        .ncoPhase       (ncoPhase),
        .carrierInSync  (carrierInSync)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkFreq(input carrierLoopPkg::loopAcc_t expected);
        if (freqWord !== expected) begin
            stopRun($sformatf("FAILED at %0t ns: freqWord is %0d, expected %0d",
                              $time, freqWord, expected));
        end
    endtask

    task automatic checkSync(input logic expected);
        if (carrierInSync !== expected) begin
            stopRun($sformatf("FAILED at %0t ns: carrierInSync is %b, expected %b",
                              $time, carrierInSync, expected));
        end
    endtask

    task automatic checkPhase(input carrierLoopPkg::ncoPhase_t expected);
        if (ncoPhase !== expected) begin
            stopRun($sformatf("FAILED at %0t ns: ncoPhase is %h, expected %h",
                              $time, ncoPhase, expected));
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // round half up to 8 bits and clip to the signed range
    function automatic int conditionError(input int raw);
        int r;
        r = (raw + 8) >>> 4;
        if (r > 127) r = 127;
        if (r < -128) r = -128;
        return r;
    endfunction

    task automatic updateLockModel(input int raw);
        int r;
        int mag;
        r = conditionError(raw);
        mag = (r < 0) ? -r : r;
        if (mag >= thrCfg) begin
            lockRun = 0;
            lockModel = 1'b0;
        end else if (!lockModel) begin
            if (lockRun == `LOCK_COUNT) lockModel = 1'b1;
            else lockRun++;
        end
    endtask

    task automatic runSample(input int raw, input int tag, input int expFreq, input int expSync);
        @(posedge clk);
        phaseError <= carrierLoopPkg::rawError_t'(raw);
        errorValid <= 1'b1;
        updateLockModel(raw);
        @(posedge clk);
        errorValid <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);  // freqWord settled 3 edges after the valid was taken
        if (tag == 1) begin
            checkFreq(carrierLoopPkg::loopAcc_t'(expFreq));
            checkSync(expSync[0]);
        end else begin
            checkSync(lockModel);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic loadTests();
        int fd;
        int n;
        string line;
        int f[9];
        fd = $fopen("bench/carrierLoopTests.txt", "r");
        if (fd == 0) stopRun("could not open bench/carrierLoopTests.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    tagQ.push_back(f[0]);
                    errQ.push_back(f[1]);
                    leadQ.push_back(f[2]);
                    lagQ.push_back(f[3]);
                    limitQ.push_back(f[4]);
                    sweepQ.push_back(f[5]);
                    thrQ.push_back(f[6]);
                    freqQ.push_back(f[7]);
                    syncQ.push_back(f[8]);
                end
            end
        end
        $fclose(fd);
    endtask

    // NCO reference built from the freqWord actually seen
    always @(negedge clk) begin
        phaseModel = phaseModel + lastFreq;
        checkPhase(phaseModel[`ACC_W-1 -: `PHASE_OUT_W]);
        lastFreq = freqWord;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            stopRun($sformatf("timeout, the run took more than %0d cycles", timeoutLimit));
        end
    end

    initial begin
        reset = 1'b1;
        phaseError = '0;
        errorValid = 1'b0;
        leadExp = '0;
        lagExp = '0;
        limit = '0;
        sweepOffsetMag = '0;
        lockThreshold = '0;
        loadTests();
        if (tagQ.size() == 0) stopRun("the tests file holds no data lines");
        timeoutLimit = tagQ.size() * 6 + 50;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < tagQ.size(); i++) begin
            if (tagQ[i] == 0) begin
                @(posedge clk);
                leadExp <= carrierLoopPkg::gainExp_t'(leadQ[i]);
                lagExp <= carrierLoopPkg::gainExp_t'(lagQ[i]);
                limit <= carrierLoopPkg::loopAcc_t'(limitQ[i]);
                sweepOffsetMag <= carrierLoopPkg::loopAcc_t'(sweepQ[i]);
                lockThreshold <= carrierLoopPkg::loopError_t'(thrQ[i]);
                thrCfg = thrQ[i];
            end else if (tagQ[i] == 2) begin
                randState = lcgNext(randState);
                runSample(int'((randState >> 16) % 97) - 48, 2, 0, 0); // small padding error
            end else begin
                runSample(errQ[i], 1, freqQ[i], syncQ[i]);
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- bench/carrierLoopTests.txt
# tag(0 config, 1 sample, 2 padding) phaseError leadExp lagExp limit sweepOffsetMag
# lockThreshold expectedFreqWord expectedInSync
0 0 7 0 1000 0 8 0 0
1 160 7 0 1000 0 8 10 0
1 -200 7 0 1000 0 8 -12 0
0 0 10 0 1000 0 8 0 0
1 2047 10 0 1000 0 8 1016 0
0 0 4 0 1000 0 8 0 0
1 -2048 4 0 1000 0 8 -16 0
0 0 9 0 1000 0 8 0 0
1 23 9 0 1000 0 8 4 0
0 0 0 0 1000 0 8 0 0
1 500 0 0 1000 0 8 0 0
0 0 7 12 1000 0 8 0 0
1 800 7 12 1000 0 8 50 0
1 800 7 12 1000 0 8 1050 0
1 800 7 12 1000 0 8 1050 0
1 -800 7 12 1000 0 8 950 0
1 -800 7 12 1000 0 8 -650 0
1 -800 7 12 1000 0 8 -1050 0
1 -800 7 12 1000 0 8 -1050 0
0 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
2 0 7 0 1000 0 8 0 0
0 0 7 7 1000 0 8 0 0
1 48 7 7 1000 0 8 -997 1
1 80 7 7 1000 0 8 -992 1
1 -96 7 7 1000 0 8 -998 1
1 112 7 7 1000 0 8 -991 1
0 0 0 0 300 100 8 0 0
1 160 0 0 300 100 8 -300 0
1 0 0 0 300 100 8 -200 0
1 0 0 0 300 100 8 -100 0
1 0 0 0 300 100 8 0 0
1 0 0 0 300 100 8 100 0
1 0 0 0 300 100 8 200 0
1 0 0 0 300 100 8 300 0
1 0 0 0 300 100 8 200 0
1 0 0 0 300 100 8 100 0
1 0 0 0 300 100 8 0 0
1 0 0 0 300 100 8 -100 0
1 0 0 0 300 100 8 -200 0
1 0 0 0 300 100 8 -300 0
1 0 0 0 300 100 8 -200 0

//--- carrierLoop.f
+incdir+hdl
hdl/carrierLoopPkg.sv
hdl/errorConditioner.sv
hdl/leadGain.sv
hdl/lagGain.sv
hdl/loopNco.sv
hdl/carrierLoop.sv
bench/carrierLoopTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the carrier loop testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module carrierLoopTb \
    -f carrierLoop.f --Mdir obj_dir -o carrierLoopSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

simOut=$(./obj_dir/carrierLoopSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -q "ALL CHECKS PASSED"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
